/* hdmi_tx_pkg.sv */
`default_nettype none

package hdmi_tx_pkg;

    // one register access on the external bus
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] wdata;
        logic       is_read;
    } reg_cmd_t;

    // result returned by the I2C master
    typedef struct packed {
        logic [7:0] rdata;
        logic       ack_error;
    } reg_rsp_t;

    typedef struct packed {
        logic [7:0] adv_reg_17;
        logic [7:0] adv_reg_3b;
        logic [7:0] adv_reg_3c;
        logic       vsync_on_polarity;
    } video_cfg_t;

    typedef struct packed {
        logic [7:0] chip_revision;
        logic [7:0] id_check_high;
        logic [7:0] id_check_low;
        logic [7:0] pll_status;
        logic [7:0] vic_detected;
        logic [7:0] vic_to_rx;
        logic [7:0] misc_data;
        logic [7:0] pll_errors;
    } debug_status_t;

    typedef enum logic [2:0] {
        bootstrap,
        link_down,
        init,
        pll_check,
        link_up,
        running
    } seq_phase_t;

    typedef enum logic [1:0] {
        idle,
        issue_1,
        issue_2,
        wait_done
    } bus_state_t;

    // status registers
    localparam logic [7:0] reg_chip_rev     = 8'h00;
    localparam logic [7:0] reg_id_high      = 8'hF5;
    localparam logic [7:0] reg_id_low       = 8'hF6;
    localparam logic [7:0] reg_pll_status   = 8'h9E;
    localparam logic [7:0] reg_vic_detected = 8'h3E;
    localparam logic [7:0] reg_vic_to_rx    = 8'h3D;
    localparam logic [7:0] reg_misc_data    = 8'h42;

    // configuration registers
    localparam logic [7:0] reg_power        = 8'h41;
    localparam logic [7:0] reg_tmds_pd      = 8'hD6;
    localparam logic [7:0] reg_tx_pd        = 8'hA1;
    localparam logic [7:0] reg_out_fmt      = 8'h16;
    localparam logic [7:0] reg_vid_17       = 8'h17;
    localparam logic [7:0] reg_vid_3b       = 8'h3B;
    localparam logic [7:0] reg_vid_3c       = 8'h3C;

    localparam int pll_lock_bit = 4;

endpackage

`default_nettype wire

/* hdmi_cfg_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_cfg_sequencer
    import hdmi_tx_pkg::*;
#(
    parameter bit output_ycbcr422 = 1'b0
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       hdmi_int,
    input  wire video_cfg_t video_cfg,
    output logic            seq_req,
    output reg_cmd_t        seq_cmd,
    input  wire logic       seq_done,
    input  wire logic [7:0] bus_rdata,
    output logic            ready,
    output logic [7:0]      pll_errors
);

    // 4:2:2 YCbCr output sets bit 7 and the black image colorspace bit
    localparam logic [7:0] out_fmt = output_ycbcr422 ? 8'hB1 : 8'h30;

    seq_phase_t phase;
    logic [3:0] step;
    logic       int_pending;
    logic       last_step;
    logic       load_cmd;
    reg_cmd_t   next_cmd;

    function automatic reg_cmd_t wr(input logic [7:0] addr, input logic [7:0] data);
        return '{reg_addr: addr, wdata: data, is_read: 1'b0};
    endfunction

    function automatic reg_cmd_t rd(input logic [7:0] addr);
        return '{reg_addr: addr, wdata: 8'h00, is_read: 1'b1};
    endfunction

    // write tables, one entry per step
    always_comb begin
        next_cmd  = wr(8'h00, 8'h00);
        last_step = 1'b0;
        case (phase)
            bootstrap: begin
                last_step = (step == 4'd10);
                case (step)
                    4'd0:    next_cmd = wr(reg_power, 8'h10);
                    4'd1:    next_cmd = wr(8'h98, 8'h03);
                    4'd2:    next_cmd = wr(8'h9A, 8'hE0);
                    4'd3:    next_cmd = wr(8'h9C, 8'h30);
                    4'd4:    next_cmd = wr(8'h9D, 8'h01);
                    4'd5:    next_cmd = wr(8'hA2, 8'hA4);
                    4'd6:    next_cmd = wr(8'hA3, 8'hA4);
                    4'd7:    next_cmd = wr(8'hE0, 8'hD0);
                    4'd8:    next_cmd = wr(8'hF9, 8'h00);
                    4'd9:    next_cmd = wr(8'h94, 8'hC0);
                    // clears the pending interrupt flags
                    default: next_cmd = wr(8'h96, 8'hC0);
                endcase
            end
            link_down: begin
                last_step = (step == 4'd2);
                case (step)
                    4'd0:    next_cmd = wr(reg_power, 8'h10);
                    4'd1:    next_cmd = wr(reg_tmds_pd, 8'h10);
                    default: next_cmd = wr(reg_tx_pd, 8'h3C);
                endcase
            end
            init: begin
                last_step = (step == 4'd15);
                case (step)
                    4'd0:    next_cmd = wr(8'h15, 8'h00);
                    4'd1:    next_cmd = wr(reg_vid_17, video_cfg.adv_reg_17);
                    4'd2:    next_cmd = wr(reg_out_fmt, out_fmt);
                    4'd3:    next_cmd = wr(8'h55, 8'h00);
                    4'd4:    next_cmd = wr(8'h18, 8'h46);
                    4'd5:    next_cmd = wr(8'hAF, 8'h06);
                    4'd6:    next_cmd = wr(8'hBA, 8'h60);
                    4'd7:    next_cmd = wr(8'h0A, 8'h00);
                    // audio N value 0x01880 split over three registers
                    4'd8:    next_cmd = wr(8'h01, 8'h00);
                    4'd9:    next_cmd = wr(8'h02, 8'h18);
                    4'd10:   next_cmd = wr(8'h03, 8'h80);
                    4'd11:   next_cmd = wr(8'h0B, 8'h0E);
                    4'd12:   next_cmd = wr(8'h0C, 8'h05);
                    4'd13:   next_cmd = wr(8'h0D, 8'h10);
                    4'd14:   next_cmd = wr(reg_vid_3b, video_cfg.adv_reg_3b);
                    default: next_cmd = wr(reg_vid_3c, video_cfg.adv_reg_3c);
                endcase
            end
            pll_check: begin
                last_step = 1'b1;
                next_cmd  = rd(reg_pll_status);
            end
            link_up: begin
                last_step = (step == 4'd1);
                next_cmd  = (step == 4'd0) ? wr(reg_tx_pd, 8'h00) : wr(reg_tmds_pd, 8'h00);
            end
            default: begin
                last_step = 1'b0;
            end
        endcase
    end

    assign load_cmd = (phase != running) && !seq_req;

    always_ff @(posedge clk) begin
        if (load_cmd) begin
            seq_cmd <= next_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            phase       <= bootstrap;
            step        <= 4'd0;
            seq_req     <= 1'b0;
            ready       <= 1'b0;
            pll_errors  <= 8'd0;
            int_pending <= 1'b0;
        end else begin
            if (phase == running) begin
                if (int_pending || !hdmi_int) begin
                    int_pending <= 1'b0;
                    ready       <= 1'b0;
                    phase       <= bootstrap;
                    step        <= 4'd0;
                end
            end else begin
                if (!hdmi_int) begin
                    int_pending <= 1'b1;
                end
                if (load_cmd) begin
                    seq_req <= 1'b1;
                end else if (seq_done) begin
                    seq_req <= 1'b0;
                    step    <= step + 4'd1;
                    if (phase == pll_check) begin
                        step <= 4'd0;
                        if (bus_rdata[pll_lock_bit]) begin
                            phase <= link_up;
                        end else begin
                            // unlocked, count it and run the whole program again
                            pll_errors <= pll_errors + 8'd1;
                            phase      <= bootstrap;
                        end
                    end else if (last_step) begin
                        step <= 4'd0;
                        case (phase)
                            bootstrap: phase <= link_down;
                            link_down: phase <= init;
                            init:      phase <= pll_check;
                            default: begin
                                phase <= running;
                                ready <= 1'b1;
                            end
                        endcase
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdmi_status_poller.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_status_poller
    import hdmi_tx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       vsync,
    input  wire logic       vsync_on_polarity,
    input  wire logic       ready,
    output logic            poll_req,
    output reg_cmd_t        poll_cmd,
    input  wire logic       poll_done,
    input  wire logic [7:0] bus_rdata,
    output debug_status_t   status
);

    logic       vsync_q;
    logic       vsync_edge;
    logic       pending;
    logic       busy;
    logic [2:0] idx;
    logic       load_cmd;
    logic [7:0] poll_addr;

    // leaving the active level marks the end of the sync pulse
    assign vsync_edge = (vsync_q == vsync_on_polarity) && (vsync != vsync_on_polarity);

    always_comb begin
        case (idx)
            3'd0:    poll_addr = reg_chip_rev;
            3'd1:    poll_addr = reg_id_high;
            3'd2:    poll_addr = reg_id_low;
            3'd3:    poll_addr = reg_pll_status;
            3'd4:    poll_addr = reg_vic_detected;
            3'd5:    poll_addr = reg_vic_to_rx;
            default: poll_addr = reg_misc_data;
        endcase
    end

    assign load_cmd = busy && !poll_req;

    always_ff @(posedge clk) begin
        if (load_cmd) begin
            poll_cmd <= '{reg_addr: poll_addr, wdata: 8'h00, is_read: 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            vsync_q  <= 1'b0;
            pending  <= 1'b0;
            busy     <= 1'b0;
            idx      <= 3'd0;
            poll_req <= 1'b0;
            status   <= '0;
        end else begin
            vsync_q <= vsync;

            if (!busy && pending && ready) begin
                busy    <= 1'b1;
                idx     <= 3'd0;
                pending <= 1'b0;
            end
            // a second edge during a poll is held as one trigger
            if (vsync_edge && ready) begin
                pending <= 1'b1;
            end

            if (load_cmd) begin
                poll_req <= 1'b1;
            end else if (poll_done) begin
                poll_req <= 1'b0;
                case (idx)
                    3'd0:    status.chip_revision <= bus_rdata;
                    3'd1:    status.id_check_high <= bus_rdata;
                    3'd2:    status.id_check_low  <= bus_rdata;
                    3'd3:    status.pll_status    <= bus_rdata;
                    3'd4:    status.vic_detected  <= bus_rdata;
                    3'd5:    status.vic_to_rx     <= bus_rdata;
                    default: status.misc_data     <= bus_rdata;
                endcase
                if (idx == 3'd6) begin
                    busy <= 1'b0;
                end else begin
                    idx <= idx + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* i2c_cmd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_arbiter
    import hdmi_tx_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     seq_req,
    input  wire reg_cmd_t seq_cmd,
    output logic          seq_done,
    input  wire logic     poll_req,
    input  wire reg_cmd_t poll_cmd,
    output logic          poll_done,
    output logic [7:0]    bus_rdata,
    output reg_cmd_t      i2c_cmd,
    output logic          i2c_enable,
    input  wire logic     i2c_done,
    input  wire reg_rsp_t i2c_rsp
);

    bus_state_t state;
    logic       owner_poll;
    logic       grant_seq;
    logic       grant_poll;
    logic       finish;

    // no grant while a done pulse is out, the owner still holds req then
    assign grant_seq  = (state == idle) && i2c_done && !seq_done && !poll_done && seq_req;
    assign grant_poll = (state == idle) && i2c_done && !seq_done && !poll_done
                        && !seq_req && poll_req;

    assign finish = (state == wait_done) && i2c_done && !i2c_rsp.ack_error;

    always_ff @(posedge clk) begin
        if (grant_seq) begin
            i2c_cmd <= seq_cmd;
        end else if (grant_poll) begin
            i2c_cmd <= poll_cmd;
        end
        if (finish) begin
            bus_rdata <= i2c_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state      <= idle;
            i2c_enable <= 1'b0;
            owner_poll <= 1'b0;
            seq_done   <= 1'b0;
            poll_done  <= 1'b0;
        end else begin
            seq_done  <= 1'b0;
            poll_done <= 1'b0;
            case (state)
                idle: begin
                    if (grant_seq || grant_poll) begin
                        owner_poll <= grant_poll;
                        i2c_enable <= 1'b1;
                        state      <= issue_1;
                    end
                end
                issue_1: begin
                    state <= issue_2;
                end
                issue_2: begin
                    i2c_enable <= 1'b0;
                    state      <= wait_done;
                end
                wait_done: begin
                    if (i2c_done) begin
                        if (i2c_rsp.ack_error) begin
                            // command register still holds the failed transfer
                            i2c_enable <= 1'b1;
                            state      <= issue_1;
                        end else begin
                            seq_done  <= !owner_poll;
                            poll_done <= owner_poll;
                            state     <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdmi_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_tx_ctrl
    import hdmi_tx_pkg::*;
#(
    parameter bit output_ycbcr422 = 1'b0
) (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       hdmi_int,
    input  wire logic       vsync,
    input  wire video_cfg_t video_cfg,
    output reg_cmd_t        i2c_cmd,
    output logic            i2c_enable,
    input  wire logic       i2c_done,
    input  wire reg_rsp_t   i2c_rsp,
    output logic            ready,
    output debug_status_t   debug_status
);

    logic          seq_req;
    reg_cmd_t      seq_cmd;
    logic          seq_done;
    logic          poll_req;
    reg_cmd_t      poll_cmd;
    logic          poll_done;
    logic [7:0]    bus_rdata;
    logic [7:0]    pll_errors;
    debug_status_t poll_status;

    hdmi_cfg_sequencer #(
        .output_ycbcr422 (output_ycbcr422)
    ) u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .hdmi_int   (hdmi_int),
        .video_cfg  (video_cfg),
        .seq_req    (seq_req),
        .seq_cmd    (seq_cmd),
        .seq_done   (seq_done),
        .bus_rdata  (bus_rdata),
        .ready      (ready),
        .pll_errors (pll_errors)
    );

    hdmi_status_poller u_poller (
        .clk               (clk),
        .reset             (reset),
        .vsync             (vsync),
        .vsync_on_polarity (video_cfg.vsync_on_polarity),
        .ready             (ready),
        .poll_req          (poll_req),
        .poll_cmd          (poll_cmd),
        .poll_done         (poll_done),
        .bus_rdata         (bus_rdata),
        .status            (poll_status)
    );

    i2c_cmd_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .seq_req    (seq_req),
        .seq_cmd    (seq_cmd),
        .seq_done   (seq_done),
        .poll_req   (poll_req),
        .poll_cmd   (poll_cmd),
        .poll_done  (poll_done),
        .bus_rdata  (bus_rdata),
        .i2c_cmd    (i2c_cmd),
        .i2c_enable (i2c_enable),
        .i2c_done   (i2c_done),
        .i2c_rsp    (i2c_rsp)
    );

    // pll error count comes from the sequencer, the rest from the poller
    assign debug_status = {poll_status[63:8], pll_errors};

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // active low reset, released on a falling edge
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

endmodule

`default_nettype wire

/* hdmi_tx_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module hdmi_tx_properties
    import hdmi_tx_pkg::*;
(
    input wire logic     clk,
    input wire logic     reset,
    input wire reg_cmd_t i2c_cmd,
    input wire logic     i2c_enable,
    input wire logic     i2c_done,
    input wire logic     seq_req,
    input wire logic     ready
);

    int unsigned failures = 0;

    // issue_1 and issue_2, then low again
    enable_two_cycles: assert property (@(posedge clk) disable iff (!reset)
        $rose(i2c_enable) |=> i2c_enable ##1 !i2c_enable)
    else begin
        $error("i2c_enable was not high for exactly two cycles");
        failures++;
    end

    cmd_stable: assert property (@(posedge clk) disable iff (!reset)
        i2c_enable |=> !i2c_enable || $stable(i2c_cmd))
    else begin
        $error("i2c_cmd changed while i2c_enable was high");
        failures++;
    end

    // the master has to be idle when a new issue starts
    enable_needs_done: assert property (@(posedge clk) disable iff (!reset)
        $rose(i2c_enable) |-> $past(i2c_done))
    else begin
        $error("i2c_enable rose while i2c_done was low");
        failures++;
    end

    ready_after_seq: assert property (@(posedge clk) disable iff (!reset)
        $rose(ready) |-> !seq_req)
    else begin
        $error("ready rose while the sequencer still requested the bus");
        failures++;
    end

endmodule

`default_nettype wire

/* tb_hdmi_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_tx_ctrl
    import hdmi_tx_pkg::*;
();

    localparam real clk_period_ns   = 8.0;
    localparam int  max_transfers   = 40;
    localparam int  max_xfer_cycles = 12;
    localparam int  max_runs        = 6;
    localparam real watchdog_ns     = max_transfers * max_xfer_cycles * max_runs * clk_period_ns;

    logic          clk;
    logic          reset;
    logic          hdmi_int;
    logic          vsync;
    video_cfg_t    video_cfg;
    reg_cmd_t      i2c_cmd;
    logic          i2c_enable;
    logic          i2c_done;
    reg_rsp_t      i2c_rsp;
    logic          ready;
    debug_status_t debug_status;

    // register image of the HDMI transmitter seen by the slave model
    logic [7:0]    image [256];
    reg_cmd_t      log_q [$];
    reg_cmd_t      exp_q [$];
    logic [31:0]   rng_state;
    int            xfer_count;
    bit            ack_error_armed;
    bit            unlock_armed;
    bit            xfer_active;

    tb_clock_gen #(
        .period_ns    (clk_period_ns),
        .reset_cycles (4)
    ) u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    hdmi_tx_ctrl #(
        .output_ycbcr422 (1'b0)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .hdmi_int     (hdmi_int),
        .vsync        (vsync),
        .video_cfg    (video_cfg),
        .i2c_cmd      (i2c_cmd),
        .i2c_enable   (i2c_enable),
        .i2c_done     (i2c_done),
        .i2c_rsp      (i2c_rsp),
        .ready        (ready),
        .debug_status (debug_status)
    );

    bind hdmi_tx_ctrl hdmi_tx_properties u_props (
        .clk        (clk),
        .reset      (reset),
        .i2c_cmd    (i2c_cmd),
        .i2c_enable (i2c_enable),
        .i2c_done   (i2c_done),
        .seq_req    (seq_req),
        .ready      (ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_cmd(input logic [7:0] addr, input logic [7:0] data, input logic rd);
        reg_cmd_t cmd;
        cmd = '{reg_addr: addr, wdata: data, is_read: rd};
        exp_q.push_back(cmd);
    endtask

    // bootstrap, link down, init and the lock read
    task automatic expect_config_writes();
        expect_cmd(8'h41, 8'h10, 1'b0);
        expect_cmd(8'h98, 8'h03, 1'b0);
        expect_cmd(8'h9A, 8'hE0, 1'b0);
        expect_cmd(8'h9C, 8'h30, 1'b0);
        expect_cmd(8'h9D, 8'h01, 1'b0);
        expect_cmd(8'hA2, 8'hA4, 1'b0);
        expect_cmd(8'hA3, 8'hA4, 1'b0);
        expect_cmd(8'hE0, 8'hD0, 1'b0);
        expect_cmd(8'hF9, 8'h00, 1'b0);
        expect_cmd(8'h94, 8'hC0, 1'b0);
        expect_cmd(8'h96, 8'hC0, 1'b0);
        expect_cmd(8'h41, 8'h10, 1'b0);
        expect_cmd(8'hD6, 8'h10, 1'b0);
        expect_cmd(8'hA1, 8'h3C, 1'b0);
        expect_cmd(8'h15, 8'h00, 1'b0);
        expect_cmd(8'h17, video_cfg.adv_reg_17, 1'b0);
        // rgb output format
        expect_cmd(8'h16, 8'h30, 1'b0);
        expect_cmd(8'h55, 8'h00, 1'b0);
        expect_cmd(8'h18, 8'h46, 1'b0);
        expect_cmd(8'hAF, 8'h06, 1'b0);
        expect_cmd(8'hBA, 8'h60, 1'b0);
        expect_cmd(8'h0A, 8'h00, 1'b0);
        expect_cmd(8'h01, 8'h00, 1'b0);
        expect_cmd(8'h02, 8'h18, 1'b0);
        expect_cmd(8'h03, 8'h80, 1'b0);
        expect_cmd(8'h0B, 8'h0E, 1'b0);
        expect_cmd(8'h0C, 8'h05, 1'b0);
        expect_cmd(8'h0D, 8'h10, 1'b0);
        expect_cmd(8'h3B, video_cfg.adv_reg_3b, 1'b0);
        expect_cmd(8'h3C, video_cfg.adv_reg_3c, 1'b0);
        expect_cmd(reg_pll_status, 8'h00, 1'b1);
    endtask

    task automatic expect_link_up();
        expect_cmd(8'hA1, 8'h00, 1'b0);
        expect_cmd(8'hD6, 8'h00, 1'b0);
    endtask

    task automatic check_log(input string what);
        assert (log_q.size() == exp_q.size()) else
            report_failure($sformatf("FAIL log size in %s: got %h expected %h",
                                     what, log_q.size(), exp_q.size()));
        foreach (exp_q[i]) begin
            assert (log_q[i] == exp_q[i]) else
                report_failure($sformatf("FAIL i2c_cmd[%0d] in %s: got %h expected %h",
                                         i, what, log_q[i], exp_q[i]));
        end
        log_q.delete();
        exp_q.delete();
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else
            report_failure($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    endtask

    task automatic wait_ready();
        while (ready !== 1'b1) @(negedge clk);
    endtask

    task automatic pulse_int();
        @(negedge clk);
        hdmi_int = 1'b0;
        @(negedge clk);
        hdmi_int = 1'b1;
        check_byte("ready", {7'd0, ready}, 8'h00);
    endtask

    // slave side of one transfer with the response driven on falling edges
    task automatic run_transfer();
        reg_cmd_t   cmd;
        int         latency;
        bit         nack;
        logic [7:0] rdata;
        cmd = i2c_cmd;
        log_q.push_back(cmd);
        xfer_active = 1'b1;
        xfer_count++;
        nack = ack_error_armed && (xfer_count == 3);
        if (nack) begin
            ack_error_armed = 1'b0;
        end
        rng_state = xorshift32(rng_state);
        latency = 3 + int'(rng_state[2:0]);
        @(negedge clk);
        i2c_done = 1'b0;
        i2c_rsp  = '0;
        repeat (latency) @(negedge clk);
        rdata = 8'h00;
        if (cmd.is_read) begin
            rdata = image[cmd.reg_addr];
            if (unlock_armed && cmd.reg_addr == reg_pll_status) begin
                rdata[pll_lock_bit] = 1'b0;
                unlock_armed = 1'b0;
            end
        end else if (!nack) begin
            image[cmd.reg_addr] = cmd.wdata;
        end
        i2c_rsp     = '{rdata: rdata, ack_error: nack};
        i2c_done    = 1'b1;
        xfer_active = 1'b0;
    endtask

    always @(negedge clk) begin
        if (reset && i2c_enable && i2c_done) begin
            run_transfer();
        end
    end

    // bus protocol violations flagged by the bound checker
    always @(u_dut.u_props.failures) begin
        if (u_dut.u_props.failures != 0) begin
            report_failure("a bound bus property failed, see the assertion error above");
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        report_failure("watchdog expired before all test phases finished");
    end

    initial begin : stimulus
        int addr;
        hdmi_int  = 1'b1;
        vsync     = 1'b0;
        video_cfg = '{adv_reg_17: 8'h02, adv_reg_3b: 8'h80, adv_reg_3c: 8'h10,
                      vsync_on_polarity: 1'b1};
        i2c_done        = 1'b1;
        i2c_rsp         = '0;
        rng_state       = 32'h4c4b4aba;
        xfer_count      = 0;
        ack_error_armed = 1'b1;
        unlock_armed    = 1'b0;
        xfer_active     = 1'b0;
        for (addr = 0; addr < 256; addr++) begin
            image[addr] = 8'(addr * 7) ^ 8'h5C;
        end
        // pll reports locked
        image[reg_pll_status][pll_lock_bit] = 1'b1;

        repeat (2) @(negedge clk);
        check_byte("ready", {7'd0, ready}, 8'h00);
        check_byte("i2c_enable", {7'd0, i2c_enable}, 8'h00);
        while (!reset) @(negedge clk);

        // first run with the third transfer repeated after its ack error
        expect_config_writes();
        expect_link_up();
        exp_q.insert(3, exp_q[2]);
        wait_ready();
        check_log("first run");

        // status poll at the end of the sync pulse
        @(negedge clk);
        vsync = 1'b1;
        repeat (3) @(negedge clk);
        vsync = 1'b0;
        while (log_q.size() < 7 || xfer_active) @(negedge clk);
        repeat (3) @(negedge clk);
        expect_cmd(reg_chip_rev, 8'h00, 1'b1);
        expect_cmd(reg_id_high, 8'h00, 1'b1);
        expect_cmd(reg_id_low, 8'h00, 1'b1);
        expect_cmd(reg_pll_status, 8'h00, 1'b1);
        expect_cmd(reg_vic_detected, 8'h00, 1'b1);
        expect_cmd(reg_vic_to_rx, 8'h00, 1'b1);
        expect_cmd(reg_misc_data, 8'h00, 1'b1);
        check_log("status poll");
        check_byte("chip_revision", debug_status.chip_revision, image[reg_chip_rev]);
        check_byte("id_check_high", debug_status.id_check_high, image[reg_id_high]);
        check_byte("id_check_low", debug_status.id_check_low, image[reg_id_low]);
        check_byte("pll_status", debug_status.pll_status, image[reg_pll_status]);
        check_byte("vic_detected", debug_status.vic_detected, image[reg_vic_detected]);
        check_byte("vic_to_rx", debug_status.vic_to_rx, image[reg_vic_to_rx]);
        check_byte("misc_data", debug_status.misc_data, image[reg_misc_data]);

        // interrupt restart
        pulse_int();
        expect_config_writes();
        expect_link_up();
        wait_ready();
        check_log("interrupt restart");

        // restart with one unlocked pll reading
        unlock_armed = 1'b1;
        pulse_int();
        expect_config_writes();
        expect_config_writes();
        expect_link_up();
        wait_ready();
        check_log("pll unlock restart");
        check_byte("pll_errors", debug_status.pll_errors, 8'h01);

        repeat (4) @(negedge clk);
        if (u_dut.u_props.failures == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_failure($sformatf("bound bus properties failed %0d times",
                                     u_dut.u_props.failures));
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
hdmi_tx_pkg.sv
hdmi_cfg_sequencer.sv
hdmi_status_poller.sv
i2c_cmd_arbiter.sv
hdmi_tx_ctrl.sv
tb_clock_gen.sv
hdmi_tx_properties.sv
tb_hdmi_tx_ctrl.sv

/* Bender.yml */
package:
  name: hdmi_tx_ctrl

sources:
  - hdmi_tx_pkg.sv
  - hdmi_cfg_sequencer.sv
  - hdmi_status_poller.sv
  - i2c_cmd_arbiter.sv
  - hdmi_tx_ctrl.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - hdmi_tx_properties.sv
      - tb_hdmi_tx_ctrl.sv
